/* rtl/hyper_axi_pkg.sv */
// HyperBus AXI front end shared definitions
// Bus widths, the AXI address view and the AXI response codes
package hyper_axi_pkg;

    // ========================================================================
    // Widths
    // ========================================================================
    localparam int unsigned AXI_ADDR_W    = 32;
    localparam int unsigned DATA_W        = 16;
    localparam int unsigned STRB_W        = DATA_W / 8;
    localparam int unsigned LEN_W         = 8;
    // Up to 256 words per transfer
    localparam int unsigned HYPER_BLEN_W  = 9;
    localparam int unsigned NUM_CHIPS     = 2;
    localparam int unsigned CHIP_OFFSET_W = 24;
    localparam int unsigned HYPER_ADDR_W  = CHIP_OFFSET_W - 1;

    // W buffer
    localparam int unsigned WFIFO_DEPTH   = 8;
    localparam int unsigned WFIFO_PTR_W   = $clog2(WFIFO_DEPTH);

    // ========================================================================
    // AXI response codes
    // ========================================================================
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // ========================================================================
    // AXI address, seen raw or split into chip index and byte offset
    // ========================================================================
    typedef struct packed {
        logic [6:0]               unused;
        logic                     chip;
        logic [CHIP_OFFSET_W-1:0] offset;
    } hyper_axi_addr_fields_t;

    typedef union packed {
        logic [AXI_ADDR_W-1:0]  raw;
        hyper_axi_addr_fields_t fields;
    } hyper_axi_addr_u;

endpackage

/* rtl/hyper_ax_arbiter.sv */
`timescale 1ns/1ps
// AX arbiter: round-robin choice between AR and AW, held in a two-slot
// spill register before the command side
module hyper_ax_arbiter
    import hyper_axi_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic [AXI_ADDR_W-1:0] ar_addr_i,
    input  logic [LEN_W-1:0]      ar_len_i,
    input  logic                  ar_valid_i,
    output logic                  ar_ready_o,
    input  logic [AXI_ADDR_W-1:0] aw_addr_i,
    input  logic [LEN_W-1:0]      aw_len_i,
    input  logic                  aw_valid_i,
    output logic                  aw_ready_o,
    output logic [AXI_ADDR_W-1:0] ax_addr_o,
    output logic [LEN_W-1:0]      ax_len_o,
    output logic                  ax_write_o,
    output logic                  ax_valid_o,
    input  logic                  ax_ready_i
);

    logic                      prio_q;
    logic                      grant_ar;
    logic                      grant_aw;
    logic                      in_valid;
    logic                      in_ready;
    logic [AXI_ADDR_W+LEN_W:0] in_data;
    logic [AXI_ADDR_W+LEN_W:0] a_data_q;
    logic [AXI_ADDR_W+LEN_W:0] b_data_q;
    logic [AXI_ADDR_W+LEN_W:0] out_data;
    logic                      a_full_q;
    logic                      b_full_q;
    logic                      a_fill;
    logic                      a_drain;
    logic                      b_fill;
    logic                      b_drain;

    // ========================================================================
    // Round-robin grant
    // ========================================================================
    // prio_q low favours the read
    assign grant_ar = ar_valid_i & (~aw_valid_i | ~prio_q);
    assign grant_aw = aw_valid_i & (~ar_valid_i | prio_q);

    assign in_valid   = ar_valid_i | aw_valid_i;
    assign ar_ready_o = grant_ar & in_ready;
    assign aw_ready_o = grant_aw & in_ready;
    assign in_data    = grant_aw ? {1'b1, aw_len_i, aw_addr_i} : {1'b0, ar_len_i, ar_addr_i};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            prio_q <= 1'b0;
        end else if (in_valid && in_ready && ar_valid_i && aw_valid_i) begin
            prio_q <= ~prio_q;
        end
    end

    // ========================================================================
    // Spill register
    // ========================================================================
    // Slot A takes new requests, slot B holds the older one on a stall
    assign a_fill   = in_valid & in_ready;
    assign a_drain  = a_full_q & ~b_full_q;
    assign b_fill   = a_drain & ~ax_ready_i;
    assign b_drain  = b_full_q & ax_ready_i;
    assign in_ready = ~a_full_q | ~b_full_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            a_full_q <= 1'b0;
            b_full_q <= 1'b0;
        end else begin
            a_full_q <= a_fill | (a_full_q & ~a_drain);
            b_full_q <= b_fill | (b_full_q & ~b_drain);
        end
    end

    always_ff @(posedge clk_i) begin
        if (a_fill) begin
            a_data_q <= in_data;
        end
        if (b_fill) begin
            b_data_q <= a_data_q;
        end
    end

    assign ax_valid_o = a_full_q | b_full_q;
    assign out_data   = b_full_q ? b_data_q : a_data_q;
    assign {ax_write_o, ax_len_o, ax_addr_o} = out_data;

endmodule

/* rtl/hyper_cmd_gen.sv */
`timescale 1ns/1ps
// HyperBus command generator: maps the held AX request to one PHY transfer
module hyper_cmd_gen
    import hyper_axi_pkg::*;
(
    input  logic [AXI_ADDR_W-1:0]   ax_addr_i,
    input  logic [LEN_W-1:0]        ax_len_i,
    input  logic                    ax_write_i,
    input  logic                    ax_valid_i,
    output logic                    ax_ready_o,
    input  logic                    addr_space_i,
    input  logic                    trans_active_i,
    output logic                    trans_write_o,
    output logic                    trans_addr_space_o,
    output logic [HYPER_ADDR_W-1:0] trans_addr_o,
    output logic [HYPER_BLEN_W-1:0] trans_blen_o,
    output logic [NUM_CHIPS-1:0]    trans_cs_o,
    output logic                    trans_valid_o,
    input  logic                    trans_ready_i,
    output logic                    trans_start_o
);

    hyper_axi_addr_u addr_u;

    assign addr_u.raw = ax_addr_i;

    // ========================================================================
    // Command fields
    // ========================================================================
    // Chip index to one-hot select
    always_comb begin
        trans_cs_o = '0;
        trans_cs_o[addr_u.fields.chip] = 1'b1;
    end

    // Byte offset to word address
    assign trans_addr_o       = addr_u.fields.offset[CHIP_OFFSET_W-1:1];
    // AXI length counts beats minus one
    assign trans_blen_o       = HYPER_BLEN_W'(ax_len_i) + HYPER_BLEN_W'(1);
    assign trans_write_o      = ax_write_i;
    assign trans_addr_space_o = addr_space_i;

    // ========================================================================
    // Handshake
    // ========================================================================
    // Only one transfer on the bus at a time
    assign trans_valid_o = ax_valid_i & ~trans_active_i;
    assign ax_ready_o    = trans_ready_i & ~trans_active_i;
    assign trans_start_o = trans_valid_o & trans_ready_i;

endmodule

/* rtl/hyper_wdata_fifo.sv */
`timescale 1ns/1ps
// W data buffer: eight-entry FIFO, drained to the PHY only during a write
module hyper_wdata_fifo
    import hyper_axi_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic [DATA_W-1:0] w_data_i,
    input  logic [STRB_W-1:0] w_strb_i,
    input  logic              w_last_i,
    input  logic              w_valid_i,
    output logic              w_ready_o,
    input  logic              wr_enable_i,
    output logic [DATA_W-1:0] tx_data_o,
    output logic [STRB_W-1:0] tx_strb_o,
    output logic              tx_last_o,
    output logic              tx_valid_o,
    input  logic              tx_ready_i
);

    logic [DATA_W-1:0]    data_mem [WFIFO_DEPTH];
    logic [STRB_W-1:0]    strb_mem [WFIFO_DEPTH];
    logic                 last_mem [WFIFO_DEPTH];
    logic [WFIFO_PTR_W-1:0] wr_ptr_q;
    logic [WFIFO_PTR_W-1:0] rd_ptr_q;
    logic [WFIFO_PTR_W:0]   count_q;
    logic                 push;
    logic                 pop;

    assign w_ready_o  = (count_q != (WFIFO_PTR_W + 1)'(WFIFO_DEPTH));
    assign tx_valid_o = (count_q != '0) & wr_enable_i;

    assign push = w_valid_i & w_ready_o;
    assign pop  = tx_valid_o & tx_ready_i;

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + (WFIFO_PTR_W + 1)'(push) - (WFIFO_PTR_W + 1)'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            data_mem[wr_ptr_q] <= w_data_i;
            strb_mem[wr_ptr_q] <= w_strb_i;
            last_mem[wr_ptr_q] <= w_last_i;
        end
    end

    // Head entry straight from storage
    assign tx_data_o = data_mem[rd_ptr_q];
    assign tx_strb_o = strb_mem[rd_ptr_q];
    assign tx_last_o = last_mem[rd_ptr_q];

endmodule

/* rtl/hyper_trans_tracker.sv */
`timescale 1ns/1ps
// Transfer tracker: active and write-ready state, PHY responses to AXI R and B
module hyper_trans_tracker
    import hyper_axi_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              trans_start_i,
    input  logic              cmd_write_i,
    input  logic              tx_done_i,
    input  logic [DATA_W-1:0] rx_data_i,
    input  logic              rx_error_i,
    input  logic              rx_last_i,
    input  logic              rx_valid_i,
    output logic              rx_ready_o,
    output logic [DATA_W-1:0] r_data_o,
    output logic [1:0]        r_resp_o,
    output logic              r_last_o,
    output logic              r_valid_o,
    input  logic              r_ready_i,
    input  logic              b_error_i,
    input  logic              b_valid_i,
    output logic              b_ready_o,
    output logic [1:0]        b_resp_o,
    output logic              b_valid_o,
    input  logic              b_ready_i,
    output logic              trans_active_o,
    output logic              wr_enable_o
);

    logic active_q;
    logic active_reset;
    logic wready_q;

    // ========================================================================
    // Transfer state
    // ========================================================================
    // Ends on the last read beat or on the write acknowledge
    assign active_reset = (rx_valid_i & rx_ready_o & rx_last_i) | (b_valid_i & b_ready_o);

    // Set wins, a new transfer can only start once the old one ended
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            active_q <= 1'b0;
            wready_q <= 1'b0;
        end else begin
            if (trans_start_i) begin
                active_q <= 1'b1;
            end else if (active_reset) begin
                active_q <= 1'b0;
            end
            if (trans_start_i && cmd_write_i) begin
                wready_q <= 1'b1;
            end else if (tx_done_i) begin
                wready_q <= 1'b0;
            end
        end
    end

    assign trans_active_o = active_q;
    assign wr_enable_o    = wready_q;

    // ========================================================================
    // Response channels
    // ========================================================================
    assign r_data_o   = rx_data_i;
    assign r_resp_o   = rx_error_i ? RESP_SLVERR : RESP_OKAY;
    assign r_last_o   = rx_last_i;
    assign r_valid_o  = rx_valid_i;
    assign rx_ready_o = r_ready_i;

    assign b_resp_o   = b_error_i ? RESP_SLVERR : RESP_OKAY;
    assign b_valid_o  = b_valid_i;
    assign b_ready_o  = b_ready_i;

endmodule

/* rtl/hyper_axi_top.sv */
`timescale 1ns/1ps
// HyperBus AXI front end: AXI slave port to PHY command and data streams
module hyper_axi_top
    import hyper_axi_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // AXI slave
    input  logic [AXI_ADDR_W-1:0]   ar_addr_i,
    input  logic [LEN_W-1:0]        ar_len_i,
    input  logic                    ar_valid_i,
    output logic                    ar_ready_o,
    input  logic [AXI_ADDR_W-1:0]   aw_addr_i,
    input  logic [LEN_W-1:0]        aw_len_i,
    input  logic                    aw_valid_i,
    output logic                    aw_ready_o,
    input  logic [DATA_W-1:0]       w_data_i,
    input  logic [STRB_W-1:0]       w_strb_i,
    input  logic                    w_last_i,
    input  logic                    w_valid_i,
    output logic                    w_ready_o,
    output logic [DATA_W-1:0]       r_data_o,
    output logic [1:0]              r_resp_o,
    output logic                    r_last_o,
    output logic                    r_valid_o,
    input  logic                    r_ready_i,
    output logic [1:0]              b_resp_o,
    output logic                    b_valid_o,
    input  logic                    b_ready_i,
    // PHY side
    output logic                    trans_write_o,
    output logic                    trans_addr_space_o,
    output logic [HYPER_ADDR_W-1:0] trans_addr_o,
    output logic [HYPER_BLEN_W-1:0] trans_blen_o,
    output logic [NUM_CHIPS-1:0]    trans_cs_o,
    output logic                    trans_valid_o,
    input  logic                    trans_ready_i,
    output logic [DATA_W-1:0]       tx_data_o,
    output logic [STRB_W-1:0]       tx_strb_o,
    output logic                    tx_last_o,
    output logic                    tx_valid_o,
    input  logic                    tx_ready_i,
    input  logic [DATA_W-1:0]       rx_data_i,
    input  logic                    rx_error_i,
    input  logic                    rx_last_i,
    input  logic                    rx_valid_i,
    output logic                    rx_ready_o,
    input  logic                    b_error_i,
    input  logic                    b_valid_i,
    output logic                    b_ready_o,
    // Config and status
    input  logic                    addr_space_i,
    output logic                    trans_active_o
);

    logic [AXI_ADDR_W-1:0] ax_addr;
    logic [LEN_W-1:0]      ax_len;
    logic                  ax_write;
    logic                  ax_valid;
    logic                  ax_ready;
    logic                  trans_start;
    logic                  trans_active;
    logic                  wr_enable;
    logic                  tx_done;

    // Last write beat accepted by the PHY
    assign tx_done        = tx_valid_o & tx_ready_i & tx_last_o;
    assign trans_active_o = trans_active;

    hyper_ax_arbiter i_ax_arbiter (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .ar_addr_i  (ar_addr_i),
        .ar_len_i   (ar_len_i),
        .ar_valid_i (ar_valid_i),
        .ar_ready_o (ar_ready_o),
        .aw_addr_i  (aw_addr_i),
        .aw_len_i   (aw_len_i),
        .aw_valid_i (aw_valid_i),
        .aw_ready_o (aw_ready_o),
        .ax_addr_o  (ax_addr),
        .ax_len_o   (ax_len),
        .ax_write_o (ax_write),
        .ax_valid_o (ax_valid),
        .ax_ready_i (ax_ready)
    );

    hyper_cmd_gen i_cmd_gen (
        .ax_addr_i          (ax_addr),
        .ax_len_i           (ax_len),
        .ax_write_i         (ax_write),
        .ax_valid_i         (ax_valid),
        .ax_ready_o         (ax_ready),
        .addr_space_i       (addr_space_i),
        .trans_active_i     (trans_active),
        .trans_write_o      (trans_write_o),
        .trans_addr_space_o (trans_addr_space_o),
        .trans_addr_o       (trans_addr_o),
        .trans_blen_o       (trans_blen_o),
        .trans_cs_o         (trans_cs_o),
        .trans_valid_o      (trans_valid_o),
        .trans_ready_i      (trans_ready_i),
        .trans_start_o      (trans_start)
    );

    hyper_wdata_fifo i_wdata_fifo (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .w_data_i    (w_data_i),
        .w_strb_i    (w_strb_i),
        .w_last_i    (w_last_i),
        .w_valid_i   (w_valid_i),
        .w_ready_o   (w_ready_o),
        .wr_enable_i (wr_enable),
        .tx_data_o   (tx_data_o),
        .tx_strb_o   (tx_strb_o),
        .tx_last_o   (tx_last_o),
        .tx_valid_o  (tx_valid_o),
        .tx_ready_i  (tx_ready_i)
    );

    hyper_trans_tracker i_trans_tracker (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .trans_start_i  (trans_start),
        .cmd_write_i    (trans_write_o),
        .tx_done_i      (tx_done),
        .rx_data_i      (rx_data_i),
        .rx_error_i     (rx_error_i),
        .rx_last_i      (rx_last_i),
        .rx_valid_i     (rx_valid_i),
        .rx_ready_o     (rx_ready_o),
        .r_data_o       (r_data_o),
        .r_resp_o       (r_resp_o),
        .r_last_o       (r_last_o),
        .r_valid_o      (r_valid_o),
        .r_ready_i      (r_ready_i),
        .b_error_i      (b_error_i),
        .b_valid_i      (b_valid_i),
        .b_ready_o      (b_ready_o),
        .b_resp_o       (b_resp_o),
        .b_valid_o      (b_valid_o),
        .b_ready_i      (b_ready_i),
        .trans_active_o (trans_active),
        .wr_enable_o    (wr_enable)
    );

endmodule

/* verification/hyper_axi_assertions.sv */
`timescale 1ns/1ps
// Protocol checks bound to the HyperBus AXI front end
module hyper_axi_assertions
    import hyper_axi_pkg::*;
(
    input logic                    clk_i,
    input logic                    rst_ni,
    input logic                    trans_write_o,
    input logic [HYPER_ADDR_W-1:0] trans_addr_o,
    input logic [HYPER_BLEN_W-1:0] trans_blen_o,
    input logic [NUM_CHIPS-1:0]    trans_cs_o,
    input logic                    trans_valid_o,
    input logic                    trans_ready_i,
    input logic                    trans_active_o,
    input logic [DATA_W-1:0]       tx_data_o,
    input logic                    tx_valid_o,
    input logic                    tx_ready_i,
    input logic                    rx_last_i,
    input logic                    rx_valid_i,
    input logic                    rx_ready_o,
    input logic [DATA_W-1:0]       r_data_o,
    input logic                    r_valid_o,
    input logic                    r_ready_i,
    input logic                    b_valid_i,
    input logic                    b_ready_o
);

    // Read from the testbench at the end of the run
    int unsigned fail_count = 0;

    // Active from the command handshake until the last rx beat or the acknowledge
    a_one_in_flight: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ((trans_valid_o && trans_ready_i) ||
         (trans_active_o && !(rx_valid_i && rx_ready_o && rx_last_i) &&
          !(b_valid_i && b_ready_o)))
        |=> trans_active_o && !trans_valid_o)
        else begin
            fail_count++;
            $error("transfer state lost or command offered during an active transfer");
        end

    a_tx_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_data_o))
        else begin
            fail_count++;
            $error("tx beat dropped or changed before handshake");
        end

    a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o))
        else begin
            fail_count++;
            $error("R beat dropped or changed before handshake");
        end

    // A stalled command keeps its fields
    a_cmd_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        trans_valid_o && !trans_ready_i |=> trans_valid_o && $stable(trans_cs_o) &&
            $stable(trans_addr_o) && $stable(trans_blen_o) && $stable(trans_write_o))
        else begin
            fail_count++;
            $error("command dropped or changed before handshake");
        end

endmodule

bind hyper_axi_top hyper_axi_assertions i_assertions (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .trans_write_o  (trans_write_o),
    .trans_addr_o   (trans_addr_o),
    .trans_blen_o   (trans_blen_o),
    .trans_cs_o     (trans_cs_o),
    .trans_valid_o  (trans_valid_o),
    .trans_ready_i  (trans_ready_i),
    .trans_active_o (trans_active_o),
    .tx_data_o      (tx_data_o),
    .tx_valid_o     (tx_valid_o),
    .tx_ready_i     (tx_ready_i),
    .rx_last_i      (rx_last_i),
    .rx_valid_i     (rx_valid_i),
    .rx_ready_o     (rx_ready_o),
    .r_data_o       (r_data_o),
    .r_valid_o      (r_valid_o),
    .r_ready_i      (r_ready_i),
    .b_valid_i      (b_valid_i),
    .b_ready_o      (b_ready_o)
);

/* verification/tb_hyper_axi.sv */
`timescale 1ns/1ps
// Testbench for the HyperBus AXI front end with a small PHY model
module tb_hyper_axi;
    import hyper_axi_pkg::*;

    logic clk_i = 1'b0;
    logic rst_ni;
    logic [31:0] ar_addr_i, aw_addr_i;
    logic [7:0]  ar_len_i, aw_len_i;
    logic ar_valid_i, aw_valid_i, ar_ready_o, aw_ready_o;
    logic [15:0] w_data_i, r_data_o, tx_data_o, rx_data_i;
    logic [1:0]  w_strb_i, tx_strb_o, r_resp_o, b_resp_o, trans_cs_o;
    logic w_last_i, w_valid_i, w_ready_o, r_last_o, r_valid_o, r_ready_i;
    logic b_valid_o, b_ready_i, trans_write_o, trans_addr_space_o;
    logic [22:0] trans_addr_o;
    logic [8:0]  trans_blen_o;
    logic trans_valid_o, trans_ready_i, tx_last_o, tx_valid_o, tx_ready_i;
    logic rx_error_i, rx_last_i, rx_valid_i, rx_ready_o;
    logic b_error_i, b_valid_i, b_ready_o, addr_space_i, trans_active_o;

    logic [31:0] lfsr = 32'h7b2e4dc2;
    logic [5:0]  stall_bits;
    int op_a[32], len_a[32], sp_a[32], err_a[32], blen_a[32];
    logic [31:0] addr_a[32], cs_a[32], waddr_a[32];
    logic [17:0] wq[$];
    int n_tests = 0, err_count = 0, fail_count = 0;
    int cycles = 0, limit = 0;
    bit rd_first = 1'b1;

    always #2 clk_i = ~clk_i;

    hyper_axi_top dut_i (.*);

    // ========================================================================
    // Random source
    // ========================================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    // PHY and R stalls drawn mid-cycle, applied on the edge
    always @(negedge clk_i) begin
        logic [15:0] v;
        draw_bits(6, v);
        stall_bits <= v[5:0];
    end

    always @(posedge clk_i) begin
        trans_ready_i <= |stall_bits[1:0];
        tx_ready_i    <= |stall_bits[3:2];
        r_ready_i     <= |stall_bits[5:4];
    end

    always @(posedge clk_i) begin
        cycles++;
        if (limit != 0 && cycles > limit) begin
            $display("timeout: run exceeded %0d cycles", limit);
            $display("tests failed");
            $finish;
        end
    end

    // ========================================================================
    // Checks and channel tasks
    // ========================================================================
    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic send_w(input int i);
        logic [15:0] d;
        logic [15:0] s;
        for (int b = 0; b <= len_a[i]; b++) begin
            draw_bits(16, d);
            draw_bits(2, s);
            wq.push_back({d, s[1:0]});
            w_data_i  <= d;
            w_strb_i  <= s[1:0];
            w_last_i  <= (b == len_a[i]);
            w_valid_i <= 1'b1;
            do begin
                @(negedge clk_i);
                // Data must wait in the buffer until the command is out
                check("tx_valid_o", 32'(tx_valid_o), 32'd0);
            end while (!(w_valid_i && w_ready_o));
            @(posedge clk_i);
        end
        w_valid_i <= 1'b0;
    endtask

    task automatic issue_ax(input int i);
        int pending;
        bit first;
        bit ar_hs;
        bit aw_hs;
        pending = (op_a[i] == 2) ? 2 : 1;
        first   = 1'b1;
        if (op_a[i] == 0 || op_a[i] == 2) begin
            ar_addr_i  <= addr_a[i];
            ar_len_i   <= len_a[i][7:0];
            ar_valid_i <= 1'b1;
        end
        if (op_a[i] != 0) begin
            aw_addr_i  <= addr_a[i];
            aw_len_i   <= len_a[i][7:0];
            aw_valid_i <= 1'b1;
        end
        while (pending > 0) begin
            @(negedge clk_i);
            ar_hs = ar_valid_i && ar_ready_o;
            aw_hs = aw_valid_i && aw_ready_o;
            if (op_a[i] == 2 && first && (ar_hs || aw_hs)) begin
                // Both channels asking, the grant alternates
                check("ar_ready_o", 32'(ar_ready_o), 32'(rd_first));
                check("aw_ready_o", 32'(aw_ready_o), 32'(!rd_first));
                rd_first = !rd_first;
                first    = 1'b0;
            end
            @(posedge clk_i);
            if (ar_hs) begin
                ar_valid_i <= 1'b0;
                pending--;
            end
            if (aw_hs) begin
                aw_valid_i <= 1'b0;
                pending--;
            end
        end
    endtask

    task automatic check_cmd(input int i, input bit wr);
        do begin
            @(negedge clk_i);
            // No write beat leaves before its command
            check("tx_valid_o", 32'(tx_valid_o), 32'd0);
        end while (!(trans_valid_o && trans_ready_i));
        check("trans_write_o", 32'(trans_write_o), 32'(wr));
        check("trans_cs_o", 32'(trans_cs_o), cs_a[i]);
        check("trans_addr_o", 32'(trans_addr_o), waddr_a[i]);
        check("trans_blen_o", 32'(trans_blen_o), 32'(blen_a[i]));
        check("trans_addr_space_o", 32'(trans_addr_space_o), 32'(sp_a[i]));
        @(posedge clk_i);
    endtask

    task automatic read_data(input int i);
        logic [15:0] d;
        logic [1:0]  resp;
        resp = err_a[i] != 0 ? RESP_SLVERR : RESP_OKAY;
        for (int b = 0; b <= len_a[i]; b++) begin
            draw_bits(16, d);
            rx_data_i  <= d;
            rx_last_i  <= (b == len_a[i]);
            rx_error_i <= (err_a[i] != 0);
            rx_valid_i <= 1'b1;
            do begin
                @(negedge clk_i);
                // PHY sees the master's R ready
                check("rx_ready_o", 32'(rx_ready_o), 32'(r_ready_i));
            end while (!(r_valid_o && r_ready_i));
            check("r_data_o", 32'(r_data_o), 32'(d));
            check("r_last_o", 32'(r_last_o), 32'(b == len_a[i]));
            check("r_resp_o", 32'(r_resp_o), 32'(resp));
            @(posedge clk_i);
        end
        rx_valid_i <= 1'b0;
    endtask

    task automatic write_data(input int i);
        logic [17:0] e;
        for (int b = 0; b <= len_a[i]; b++) begin
            e = wq.pop_front();
            do @(negedge clk_i); while (!(tx_valid_o && tx_ready_i));
            check("tx_data_o", 32'(tx_data_o), 32'(e[17:2]));
            check("tx_strb_o", 32'(tx_strb_o), 32'(e[1:0]));
            check("tx_last_o", 32'(tx_last_o), 32'(b == len_a[i]));
            @(posedge clk_i);
        end
        b_error_i <= (err_a[i] != 0);
        b_valid_i <= 1'b1;
        do begin
            @(negedge clk_i);
            check("b_ready_o", 32'(b_ready_o), 32'(b_ready_i));
        end while (!(b_valid_o && b_ready_i));
        check("b_resp_o", 32'(b_resp_o), 32'(err_a[i] != 0 ? RESP_SLVERR : RESP_OKAY));
        @(posedge clk_i);
        b_valid_i <= 1'b0;
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        string line;
        int fd, cnt, errs0, bursts;
        bit rd_now;
        {ar_addr_i, aw_addr_i, ar_len_i, aw_len_i, ar_valid_i, aw_valid_i} = '0;
        {w_data_i, w_strb_i, w_last_i, w_valid_i, b_ready_i} = '0;
        {trans_ready_i, tx_ready_i, r_ready_i, stall_bits} = '0;
        {rx_data_i, rx_error_i, rx_last_i, rx_valid_i} = '0;
        {b_error_i, b_valid_i, addr_space_i} = '0;
        rst_ni = 1'b0;
        fd = $fopen("verification/hyper_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
            $display("tests failed");
            $finish;
        end else begin
            bursts = 0;
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.substr(0, 0) != "#") begin
                    cnt = $sscanf(line, "%d %h %d %d %d %h %h %d", op_a[n_tests],
                        addr_a[n_tests], len_a[n_tests], sp_a[n_tests], err_a[n_tests],
                        cs_a[n_tests], waddr_a[n_tests], blen_a[n_tests]);
                    if (cnt == 8) begin
                        bursts += (op_a[n_tests] == 2 ? 2 : 1) * (len_a[n_tests] + 1);
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
            limit = 30 * bursts + 200;
            repeat (3) @(posedge clk_i);
            rst_ni    <= 1'b1;
            b_ready_i <= 1'b1;
            for (int i = 0; i < n_tests; i++) begin
                @(posedge clk_i);
                errs0 = err_count;
                addr_space_i <= sp_a[i][0];
                rd_now = (op_a[i] == 0) || (op_a[i] == 2 && rd_first);
                // Write data goes first and waits in the buffer
                if (op_a[i] != 0) begin
                    send_w(i);
                end
                fork
                    issue_ax(i);
                    begin
                        if (rd_now) begin
                            check_cmd(i, 1'b0);
                            read_data(i);
                        end
                        if (op_a[i] != 0) begin
                            check_cmd(i, 1'b1);
                            write_data(i);
                        end
                        if (op_a[i] == 2 && !rd_now) begin
                            check_cmd(i, 1'b0);
                            read_data(i);
                        end
                    end
                join
                if (err_count != errs0) fail_count++;
                $display("test %0d op %0d addr %h len %0d: %s", i, op_a[i], addr_a[i],
                    len_a[i], err_count == errs0 ? "ok" : "FAILED");
            end
            repeat (4) @(posedge clk_i);
            $display("%0d tests, %0d passed, %0d failed, %0d check errors, %0d assertion failures",
                n_tests, n_tests - fail_count, fail_count, err_count,
                dut_i.i_assertions.fail_count);
            if (fail_count == 0 && err_count == 0 && dut_i.i_assertions.fail_count == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
            $finish;
        end
    end

endmodule

/* verification/hyper_stimulus.txt */
# op (0 read, 1 write, 2 AR and AW together) addr len addr_space error
# expected: chip select, word address, burst length in words
0 00000040 3 0 0 1 000020 4
1 01000100 5 1 0 2 000080 6
0 01abcdee 0 0 1 2 55e6f7 1
1 00fffffe 7 0 1 1 7fffff 8
2 00001000 2 0 0 1 000800 3
2 01002000 1 1 1 2 001000 2
0 fe000010 4 1 0 1 000008 5
1 01800006 6 0 0 2 400003 7
2 00000200 3 1 0 1 000100 4
0 00000000 7 0 0 1 000000 8

/* filelist.f */
rtl/hyper_axi_pkg.sv
rtl/hyper_ax_arbiter.sv
rtl/hyper_cmd_gen.sv
rtl/hyper_wdata_fifo.sv
rtl/hyper_trans_tracker.sv
rtl/hyper_axi_top.sv
verification/hyper_axi_assertions.sv
verification/tb_hyper_axi.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the HyperBus AXI front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_hyper_axi -f filelist.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log

if grep -q "tests failed" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
